/* design/frontEnd_settings.svh */
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// Data and address width
`define FE_XLEN 32

// ROB index width
`define FE_ROB_WIDTH 4

// Instruction queue entries
`define FE_QUEUE_DEPTH 2

`define FE_RESET_PC 32'h0000_0000

`endif

/* design/isaPkg.sv */
`include "frontEnd_settings.svh"

package isaPkg;

  // Major opcodes kept by this front end
  typedef enum logic [6:0] {
    opLui   = 7'b0110111,
    opAuipc = 7'b0010111,
    opImm   = 7'b0010011,
    opReg   = 7'b0110011,
    opLoad  = 7'b0000011,
    opStore = 7'b0100011
  } opcodeT;

  // funct3 of OP and OP-IMM
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Shr    = 3'b101; // SRL or SRA by funct7
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // funct3 of LOAD and STORE
  localparam logic [2:0] f3Byte  = 3'b000;
  localparam logic [2:0] f3Half  = 3'b001;
  localparam logic [2:0] f3Word  = 3'b010;
  localparam logic [2:0] f3ByteU = 3'b100;
  localparam logic [2:0] f3HalfU = 3'b101;

  typedef struct packed {
    logic [`FE_XLEN-1:0] word; // Raw instruction
    logic [`FE_XLEN-1:0] addr; // Address it was fetched from
  } fetchedInstrT;

endpackage

/* design/dispatchPkg.sv */
`include "frontEnd_settings.svh"

package dispatchPkg;

  typedef enum logic [3:0] {
    aluAdd  = 4'b0000,
    aluSub  = 4'b0001,
    aluXor  = 4'b0010,
    aluOr   = 4'b0011,
    aluAnd  = 4'b0100,
    aluSll  = 4'b0101,
    aluSrl  = 4'b0110,
    aluSra  = 4'b0111,
    aluSlt  = 4'b1010,
    aluSltu = 4'b1011
  } aluOpT;

  typedef enum logic [2:0] {
    memByte  = 3'b000,
    memHalf  = 3'b001,
    memWord  = 3'b010,
    memByteU = 3'b011,
    memHalfU = 3'b100
  } memOpT;

  typedef enum logic [1:0] {
    robRegWrite = 2'b00,
    robMemWrite = 2'b10
  } robTypeT;

  typedef struct packed {
    logic [`FE_ROB_WIDTH-1:0] index;
    robTypeT                  entryType;
    logic                     ready;     // Value already known at dispatch
    logic [`FE_XLEN-1:0]      value;
    logic [4:0]               dest;
  } robEntryT;

  typedef struct packed {
    aluOpT                    op;
    logic [`FE_ROB_WIDTH-1:0] robIndex;
    logic [`FE_XLEN-1:0]      val1;
    logic                     hasDep1;
    logic [`FE_ROB_WIDTH-1:0] dep1;
    logic [`FE_XLEN-1:0]      val2;
    logic                     hasDep2;
    logic [`FE_ROB_WIDTH-1:0] dep2;
  } rsEntryT;

  typedef struct packed {
    logic                     readWrite; // High for a load
    logic [`FE_ROB_WIDTH-1:0] robId;
    logic                     hasDep;    // Base still waiting on a ROB entry
    logic [`FE_XLEN-1:0]      base;
    logic [`FE_ROB_WIDTH-1:0] depId;
    logic [`FE_XLEN-1:0]      offset;
    logic [4:0]               target;
    memOpT                    op;
  } lsbEntryT;

  typedef struct packed {
    logic                     dirty;
    logic [`FE_ROB_WIDTH-1:0] dependency;
    logic [`FE_XLEN-1:0]      value;
  } regReadT;

  typedef struct packed {
    logic                     update;
    logic [`FE_ROB_WIDTH-1:0] robIndex;
    logic [`FE_XLEN-1:0]      value;
  } resultBusT;

  typedef struct packed {
    logic [4:0]               dest;
    logic [`FE_ROB_WIDTH-1:0] robId;
  } rfUpdateT;

endpackage

/* design/fetchUnit.sv */
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module fetchUnit
  import isaPkg::*;
(
  input  logic                clockIn,
  input  logic                reset,
  input  logic                readyIn,
  input  logic                clearIn,
  input  logic [`FE_XLEN-1:0] newPc,        // Redirect target, valid with clearIn
  input  logic                instrInValid,
  input  logic [`FE_XLEN-1:0] instrIn,      // Cache word at fetchPc
  input  logic                queueFull,
  output logic [`FE_XLEN-1:0] fetchPc,
  output logic                push,
  output fetchedInstrT        pushEntry
);

  logic [`FE_XLEN-1:0] pc;

  // Take the cache word only when the queue has room and no redirect is under way
  assign push      = readyIn && instrInValid && !queueFull && !clearIn;
  assign pushEntry = '{word: instrIn, addr: pc};
  assign fetchPc   = pc;

  always_ff @(posedge clockIn) begin
    if (reset) begin
      pc <= `FE_RESET_PC;
    end else if (clearIn) begin
      pc <= newPc;
    end else if (push) begin
      pc <= pc + `FE_XLEN'(4); // Next sequential word
    end
  end

  pcAligned: assert property (
    @(posedge clockIn) disable iff (reset)
    fetchPc[1:0] == 2'b00
  ) else $error("fetchPc not word aligned");

endmodule

/* design/instrQueue.sv */
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module instrQueue
  import isaPkg::*;
(
  input  logic         clockIn,
  input  logic         reset,
  input  logic         clearIn,
  input  logic         push,
  input  fetchedInstrT pushEntry,
  input  logic         pop,
  output logic         full,
  output logic         empty,
  output fetchedInstrT head
);

  localparam int PtrWidth   = $clog2(`FE_QUEUE_DEPTH);
  localparam int CountWidth = $clog2(`FE_QUEUE_DEPTH + 1);

  fetchedInstrT          entries [`FE_QUEUE_DEPTH];
  logic [PtrWidth-1:0]   readPtr;
  logic [PtrWidth-1:0]   writePtr;
  logic [CountWidth-1:0] count;
  logic                  doPush;
  logic                  doPop;

  assign full   = count == CountWidth'(`FE_QUEUE_DEPTH);
  assign empty  = count == '0;
  assign head   = entries[readPtr];
  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  // Write side of the circular buffer
  always_ff @(posedge clockIn) begin
    if (doPush) begin
      entries[writePtr] <= pushEntry;
    end
  end

  always_ff @(posedge clockIn) begin
    if (reset || clearIn) begin
      readPtr  <= '0;
      writePtr <= '0;
      count    <= '0;
    end else begin
      if (doPush) begin
        writePtr <= (writePtr == PtrWidth'(`FE_QUEUE_DEPTH - 1)) ? '0 : writePtr + 1'b1;
      end
      if (doPop) begin
        readPtr <= (readPtr == PtrWidth'(`FE_QUEUE_DEPTH - 1)) ? '0 : readPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  noPushWhenFull: assert property (
    @(posedge clockIn) disable iff (reset) push |-> !full
  ) else $error("Push into a full instruction queue");

  noPopWhenEmpty: assert property (
    @(posedge clockIn) disable iff (reset) pop |-> !empty
  ) else $error("Pop from an empty instruction queue");

endmodule

/* design/issueUnit.sv */
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module issueUnit
  import isaPkg::*, dispatchPkg::*;
(
  input  logic                     clockIn,
  input  logic                     reset,
  input  logic                     readyIn,
  input  logic                     clearIn,
  input  logic                     empty,
  input  fetchedInstrT             head,
  output logic                     pop,
  output logic [4:0]               rs1Index,
  output logic [4:0]               rs2Index,
  input  regReadT                  rs1Read,
  input  regReadT                  rs2Read,
  input  resultBusT                rsResult,
  input  resultBusT                lsbResult,
  input  logic [`FE_ROB_WIDTH-1:0] robNext,
  input  logic                     robFull,
  input  logic                     rsFull,
  input  logic                     lsbFull,
  output robEntryT                 robAdd,
  output logic                     robAddValid,
  output rsEntryT                  rsAdd,
  output logic                     rsAddValid,
  output lsbEntryT                 lsbAdd,
  output logic                     lsbAddValid,
  output rfUpdateT                 rfUpdate,
  output logic                     rfUpdateValid
);

  // Clean register, else RS broadcast, else LSB broadcast, else keep the dependency
  function automatic regReadT resolveOperand(regReadT port, resultBusT rsBus,
                                             resultBusT lsbBus);
    regReadT result;
    result = port;
    if (port.dirty) begin
      if (rsBus.update && rsBus.robIndex == port.dependency) begin
        result.dirty = 1'b0;
        result.value = rsBus.value;
      end else if (lsbBus.update && lsbBus.robIndex == port.dependency) begin
        result.dirty = 1'b0;
        result.value = lsbBus.value;
      end else begin
        result.value = '0;
      end
    end
    return result;
  endfunction

  opcodeT              opcode;
  logic [4:0]          rd;
  logic [2:0]          funct3;
  logic                altFunct;  // funct7 bit 5, SUB and SRA
  logic [`FE_XLEN-1:0] signedImm;
  logic [`FE_XLEN-1:0] unsignedImm;
  logic [`FE_XLEN-1:0] upperImm;
  logic [`FE_XLEN-1:0] shiftImm;
  logic [`FE_XLEN-1:0] storeImm;
  regReadT             src1;
  regReadT             src2;
  logic                isUpper;
  logic                needRs;
  logic                needLsb;
  logic                known;
  logic                roomOk;
  aluOpT               aluOp;
  memOpT               memOp;
  robEntryT            robEntryD;
  rsEntryT             rsEntryD;
  lsbEntryT            lsbEntryD;

  assign opcode      = opcodeT'(head.word[6:0]);
  assign rd          = head.word[11:7];
  assign funct3      = head.word[14:12];
  assign altFunct    = head.word[30];
  assign rs1Index    = head.word[19:15];
  assign rs2Index    = head.word[24:20];
  assign signedImm   = {{20{head.word[31]}}, head.word[31:20]};
  assign unsignedImm = {20'b0, head.word[31:20]};
  assign upperImm    = {head.word[31:12], 12'b0};
  assign shiftImm    = {27'b0, head.word[24:20]};
  assign storeImm    = {{20{head.word[31]}}, head.word[31:25], head.word[11:7]};
  assign src1        = resolveOperand(rs1Read, rsResult, lsbResult);
  assign src2        = resolveOperand(rs2Read, rsResult, lsbResult);

  assign isUpper = opcode inside {opLui, opAuipc};
  assign needRs  = opcode inside {opImm, opReg};
  assign needLsb = opcode inside {opLoad, opStore};
  assign known   = isUpper || needRs || needLsb;
  assign roomOk  = !known || (!robFull && !(needRs && rsFull) && !(needLsb && lsbFull));
  assign pop     = readyIn && !empty && !clearIn && roomOk; // Unknown words just drain

  always_comb begin
    case (funct3)
      f3AddSub: aluOp = (opcode == opReg && altFunct) ? aluSub : aluAdd;
      f3Sll:    aluOp = aluSll;
      f3Slt:    aluOp = aluSlt;
      f3Sltu:   aluOp = aluSltu;
      f3Xor:    aluOp = aluXor;
      f3Shr:    aluOp = altFunct ? aluSra : aluSrl;
      f3Or:     aluOp = aluOr;
      default:  aluOp = aluAnd;
    endcase
    case (funct3)
      f3Byte:  memOp = memByte;
      f3Half:  memOp = memHalf;
      f3ByteU: memOp = memByteU;
      f3HalfU: memOp = memHalfU;
      default: memOp = memWord;
    endcase
  end

  always_comb begin
    robEntryD = '{index: robNext, entryType: robRegWrite, ready: isUpper, value: '0, dest: rd};
    if (opcode == opLui) begin
      robEntryD.value = upperImm;
    end else if (opcode == opAuipc) begin
      robEntryD.value = head.addr + upperImm;
    end else if (opcode == opStore) begin
      robEntryD.entryType = robMemWrite;
      robEntryD.dest      = '0; // Stores write no register
    end

    rsEntryD = '{op: aluOp, robIndex: robNext, val1: src1.value, hasDep1: src1.dirty,
                 dep1: src1.dependency, val2: src2.value, hasDep2: src2.dirty,
                 dep2: src2.dependency};
    if (opcode == opImm) begin
      rsEntryD.hasDep2 = 1'b0;
      rsEntryD.dep2    = '0;
      if (funct3 == f3Sll || funct3 == f3Shr) begin
        rsEntryD.val2 = shiftImm;
      end else if (funct3 == f3Sltu) begin
        rsEntryD.val2 = unsignedImm;
      end else begin
        rsEntryD.val2 = signedImm;
      end
    end

    lsbEntryD = '{readWrite: opcode == opLoad, robId: robNext, hasDep: src1.dirty,
                  base: src1.value, depId: src1.dependency,
                  offset: (opcode == opStore) ? storeImm : signedImm,
                  target: (opcode == opStore) ? rs2Index : rd, op: memOp};
  end

  always_ff @(posedge clockIn) begin
    if (reset || clearIn) begin
      robAddValid   <= 1'b0;
      rsAddValid    <= 1'b0;
      lsbAddValid   <= 1'b0;
      rfUpdateValid <= 1'b0;
    end else begin
      robAddValid   <= pop && known && !(isUpper && rd == 5'd0);
      rsAddValid    <= pop && needRs;
      lsbAddValid   <= pop && needLsb;
      rfUpdateValid <= pop && known && opcode != opStore && rd != 5'd0;
    end
  end

  // Payload only moves on a pop
  always_ff @(posedge clockIn) begin
    if (pop) begin
      robAdd   <= robEntryD;
      rsAdd    <= rsEntryD;
      lsbAdd   <= lsbEntryD;
      rfUpdate <= '{dest: rd, robId: robNext};
    end
  end

  oneExecTarget: assert property (
    @(posedge clockIn) disable iff (reset) !(rsAddValid && lsbAddValid)
  ) else $error("Instruction dispatched to both RS and LSB");

endmodule

/* design/frontEnd.sv */
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module frontEnd
  import isaPkg::*, dispatchPkg::*;
(
  input  logic                     clockIn,
  input  logic                     reset,
  input  logic                     readyIn,
  input  logic                     clearIn,
  input  logic [`FE_XLEN-1:0]      newPc,
  input  logic                     instrInValid,
  input  logic [`FE_XLEN-1:0]      instrIn,
  output logic [`FE_XLEN-1:0]      fetchPc,
  output logic [4:0]               rs1Index,
  output logic [4:0]               rs2Index,
  input  regReadT                  rs1Read,
  input  regReadT                  rs2Read,
  input  resultBusT                rsResult,
  input  resultBusT                lsbResult,
  input  logic [`FE_ROB_WIDTH-1:0] robNext,
  input  logic                     robFull,
  input  logic                     rsFull,
  input  logic                     lsbFull,
  output robEntryT                 robAdd,
  output logic                     robAddValid,
  output rsEntryT                  rsAdd,
  output logic                     rsAddValid,
  output lsbEntryT                 lsbAdd,
  output logic                     lsbAddValid,
  output rfUpdateT                 rfUpdate,
  output logic                     rfUpdateValid
);

  logic         push;       // Fetch into queue
  fetchedInstrT pushEntry;
  logic         queueFull;
  logic         queueEmpty;
  fetchedInstrT head;       // Oldest queued instruction
  logic         pop;

  fetchUnit i_fetchUnit (.*);

  instrQueue i_instrQueue (
    .full  (queueFull),
    .empty (queueEmpty),
    .*
  );

  issueUnit i_issueUnit (
    .empty (queueEmpty),
    .*
  );

endmodule

/* verification/issueModel.svh */
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

fetchedInstrT        modelQueue[$];              // Mirror of the instruction queue
logic [`FE_XLEN-1:0] modelPc = `FE_RESET_PC;
logic                expRobValid = 1'b0;
logic                expRsValid = 1'b0;
logic                expLsbValid = 1'b0;
logic                expRfValid = 1'b0;
robEntryT            expRob;
rsEntryT             expRs;
lsbEntryT            expLsb;
rfUpdateT            expRf;
int                  hitCount[4] = '{default: 0}; // Clean, RS hit, LSB hit, waiting

// Legal word of a kept opcode, now and then a dropped one
function automatic logic [31:0] makeInstr();
  logic [31:0] word;
  logic [2:0]  f3;
  logic        alt;
  word = $urandom();
  f3   = word[14:12];
  alt  = word[30] && (f3 == 3'b000 || f3 == 3'b101);
  case ($urandom() % 8)
    0: word[6:0] = opLui;
    1: word[6:0] = opAuipc;
    2: begin
      word[6:0] = opImm;
      if (f3 == 3'b001 || f3 == 3'b101) begin
        word[31:25] = {1'b0, alt, 5'b0}; // Shift forms
      end
    end
    3, 4: begin
      word[6:0]   = opReg;
      word[31:25] = {1'b0, alt, 5'b0};
    end
    5: begin
      word[6:0] = opLoad;
      if (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111) begin
        word[14:12] = 3'b010;
      end
    end
    6: begin
      word[6:0]   = opStore;
      word[14:12] = f3 % 3'd3; // SB, SH, SW only
    end
    default: word[6:0] = 7'b1101111; // JAL, not handled here
  endcase
  return word;
endfunction

// Register port after the result buses are taken into account
function automatic regReadT resolveSource(regReadT port, resultBusT rsBus,
                                          resultBusT lsbBus, output int kind);
  regReadT src;
  src  = port;
  kind = 0;
  if (port.dirty) begin
    kind      = 3;
    src.value = '0;
    if (lsbBus.update && lsbBus.robIndex == port.dependency) begin
      kind      = 2;
      src.dirty = 1'b0;
      src.value = lsbBus.value;
    end
    if (rsBus.update && rsBus.robIndex == port.dependency) begin
      kind      = 1; // RS broadcast has priority
      src.dirty = 1'b0;
      src.value = rsBus.value;
    end
  end
  return src;
endfunction

function automatic aluOpT aluFor(logic [6:0] opc, logic [2:0] f3, logic alt);
  case (f3)
    3'b000:  return (opc == opReg && alt) ? aluSub : aluAdd;
    3'b001:  return aluSll;
    3'b010:  return aluSlt;
    3'b011:  return aluSltu;
    3'b100:  return aluXor;
    3'b101:  return alt ? aluSra : aluSrl;
    3'b110:  return aluOr;
    default: return aluAnd;
  endcase
endfunction

function automatic memOpT memFor(logic [2:0] f3);
  case (f3)
    3'b000:  return memByte;
    3'b001:  return memHalf;
    3'b010:  return memWord;
    3'b100:  return memByteU;
    default: return memHalfU;
  endcase
endfunction

// One clock edge of fetch, queue and issue, from the inputs now applied
task automatic advanceModel();
  logic [31:0] w;
  logic [6:0]  opc;
  logic [4:0]  rd;
  logic [31:0] immI;
  logic [31:0] immS;
  logic [31:0] immU;
  logic        toRs;
  logic        toLsb;
  logic        canPush;
  regReadT     src1;
  regReadT     src2;
  int          kind1;
  int          kind2;
  {expRobValid, expRsValid, expLsbValid, expRfValid} = 4'b0;
  if (reset || clearIn) begin
    modelQueue.delete();
    modelPc = reset ? `FE_RESET_PC : newPc;
    return;
  end
  if (!readyIn) begin
    return;
  end
  canPush = instrInValid && modelQueue.size() < `FE_QUEUE_DEPTH;
  if (modelQueue.size() > 0) begin
    w     = modelQueue[0].word;
    opc   = w[6:0];
    rd    = w[11:7];
    immI  = {{20{w[31]}}, w[31:20]};
    immS  = {{20{w[31]}}, w[31:25], w[11:7]};
    immU  = {w[31:12], 12'b0};
    toRs  = opc == opImm || opc == opReg;
    toLsb = opc == opLoad || opc == opStore;
    src1  = resolveSource(regTable[w[19:15]], rsResult, lsbResult, kind1);
    src2  = resolveSource(regTable[w[24:20]], rsResult, lsbResult, kind2);
    if (!(robFull || (toRs && rsFull) || (toLsb && lsbFull)) ||
        !(toRs || toLsb || opc == opLui || opc == opAuipc)) begin
      expRob = '{index: robNext, entryType: robRegWrite, ready: 1'b0, value: '0, dest: rd};
      expRf  = '{dest: rd, robId: robNext};
      expRs  = '{op: aluFor(opc, w[14:12], w[30]), robIndex: robNext, val1: src1.value,
                 hasDep1: src1.dirty, dep1: src1.dependency, val2: src2.value,
                 hasDep2: src2.dirty, dep2: src2.dependency};
      expLsb = '{readWrite: opc == opLoad, robId: robNext, hasDep: src1.dirty,
                 base: src1.value, depId: src1.dependency,
                 offset: (opc == opStore) ? immS : immI,
                 target: (opc == opStore) ? w[24:20] : rd, op: memFor(w[14:12])};
      if (opc == opLui || opc == opAuipc) begin
        expRob.ready = 1'b1;
        expRob.value = (opc == opLui) ? immU : modelQueue[0].addr + immU;
        expRobValid  = rd != 5'd0;
        expRfValid   = rd != 5'd0;
      end else if (toRs || toLsb) begin
        expRobValid = 1'b1;
        expRfValid  = opc != opStore && rd != 5'd0;
        expRsValid  = toRs;
        expLsbValid = toLsb;
        hitCount[kind1]++;
      end
      if (opc == opReg) begin
        hitCount[kind2]++;
      end
      if (opc == opStore) begin
        expRob.entryType = robMemWrite;
        expRob.dest      = '0;
      end
      if (opc == opImm) begin
        expRs.hasDep2 = 1'b0;
        expRs.dep2    = '0;
        if (w[13:12] == 2'b01) begin
          expRs.val2 = {27'b0, w[24:20]}; // Shift amount
        end else begin
          expRs.val2 = (w[14:12] == 3'b011) ? {20'b0, w[31:20]} : immI;
        end
      end
      void'(modelQueue.pop_front());
    end
  end
  if (canPush) begin
    modelQueue.push_back('{word: imem[modelPc[7:2]], addr: modelPc});
    modelPc = modelPc + 32'd4;
  end
endtask

`endif

/* verification/frontEndTb.sv */
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module frontEndTb
  import isaPkg::*, dispatchPkg::*;
();

  logic                     clockIn;
  logic                     reset;
  logic                     readyIn;
  logic                     clearIn;
  logic [`FE_XLEN-1:0]      newPc;
  logic                     instrInValid;
  logic [`FE_XLEN-1:0]      instrIn;
  logic [`FE_XLEN-1:0]      fetchPc;
  logic [4:0]               rs1Index;
  logic [4:0]               rs2Index;
  regReadT                  rs1Read;
  regReadT                  rs2Read;
  resultBusT                rsResult;
  resultBusT                lsbResult;
  logic [`FE_ROB_WIDTH-1:0] robNext;
  logic                     robFull;
  logic                     rsFull;
  logic                     lsbFull;
  robEntryT                 robAdd;
  logic                     robAddValid;
  rsEntryT                  rsAdd;
  logic                     rsAddValid;
  lsbEntryT                 lsbAdd;
  logic                     lsbAddValid;
  rfUpdateT                 rfUpdate;
  logic                     rfUpdateValid;

  logic [31:0] imem [64];      // Instruction memory, wraps every 256 bytes
  regReadT     regTable [32];  // Fixed register-file answers
  logic        running;
  string       phase = "reset";
  int          issuedCount = 0;
  int          clearCount = 0;

  `include "issueModel.svh"

  frontEnd i_frontEnd (.*);

  assign instrIn = imem[fetchPc[7:2]];
  assign rs1Read = regTable[rs1Index];
  assign rs2Read = regTable[rs2Index];

  always #50 clockIn = ~clockIn;

  task automatic checkValue(string testName, logic [127:0] expected, logic [127:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %h actual %h", testName, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch in %s", testName);
    end
  endtask

  // Random environment, applied just after each rising edge
  always @(posedge clockIn) begin
    if (running) begin
      readyIn      <= ($urandom() % 8) != 0;
      instrInValid <= ($urandom() % 4) != 0;
      robFull      <= ($urandom() % 4) == 0;
      rsFull       <= ($urandom() % 4) == 0;
      lsbFull      <= ($urandom() % 4) == 0;
      clearIn      <= ($urandom() % 64) == 0;
      newPc        <= $urandom() & 32'hffff_fffc;
      robNext      <= `FE_ROB_WIDTH'($urandom());
      rsResult     <= '{update: $urandom() % 2, robIndex: $urandom() % 4, value: $urandom()};
      lsbResult    <= '{update: $urandom() % 2, robIndex: $urandom() % 4, value: $urandom()};
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clockIn) begin
    checkValue({phase, " fetchPc"}, modelPc, fetchPc);
    if (modelQueue.size() > 0) begin
      checkValue({phase, " rs1Index"}, modelQueue[0].word[19:15], rs1Index);
      checkValue({phase, " rs2Index"}, modelQueue[0].word[24:20], rs2Index);
    end
    checkValue({phase, " robAddValid"}, expRobValid, robAddValid);
    checkValue({phase, " rsAddValid"}, expRsValid, rsAddValid);
    checkValue({phase, " lsbAddValid"}, expLsbValid, lsbAddValid);
    checkValue({phase, " rfUpdateValid"}, expRfValid, rfUpdateValid);
    if (expRobValid) begin
      checkValue({phase, " robAdd"}, expRob, robAdd);
    end
    if (expRsValid) begin
      checkValue({phase, " rsAdd"}, expRs, rsAdd);
    end
    if (expLsbValid) begin
      checkValue({phase, " lsbAdd"}, expLsb, lsbAdd);
    end
    if (expRfValid) begin
      checkValue({phase, " rfUpdate"}, expRf, rfUpdate);
    end
    if (robAddValid || rsAddValid || lsbAddValid) begin
      issuedCount++;
    end
    if (clearIn && !reset) begin
      clearCount++;
    end
    advanceModel();
  end

  initial begin
    int cycles;
    void'($urandom(32'h4c7940ac));
    clockIn      = 1'b0;
    reset        = 1'b1;
    running      = 1'b0;
    readyIn      = 1'b0;
    clearIn      = 1'b0;
    newPc        = '0;
    instrInValid = 1'b0;
    robFull      = 1'b0;
    rsFull       = 1'b0;
    lsbFull      = 1'b0;
    rsResult     = '0;
    lsbResult    = '0;
    robNext      = '0;
    foreach (imem[i]) begin
      imem[i] = makeInstr();
    end
    foreach (regTable[i]) begin
      regTable[i] = '{dirty: $urandom() % 2, dependency: $urandom() % 4, value: $urandom()};
    end
    repeat (8) @(posedge clockIn);
    reset   <= 1'b0;
    running <= 1'b1;
    phase = "random";
    cycles = 0;
    while (issuedCount < 400 || clearCount < 3) begin
      @(posedge clockIn);
      cycles++;
      if (cycles > 20000) begin
        $display("Timeout: %0d issued and %0d clears in %0d cycles",
                 issuedCount, clearCount, cycles);
        $display("ERRORS FOUND");
        $fatal(1, "Front end stopped issuing");
      end
    end
    phase = "coverage";
    checkValue("coverage cleanOperand", 1, hitCount[0] > 0);
    checkValue("coverage rsForward", 1, hitCount[1] > 0);
    checkValue("coverage lsbForward", 1, hitCount[2] > 0);
    checkValue("coverage unresolved", 1, hitCount[3] > 0);
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* all.f */
+incdir+design
+incdir+verification
design/isaPkg.sv
design/dispatchPkg.sv
design/fetchUnit.sv
design/instrQueue.sv
design/issueUnit.sv
design/frontEnd.sv
verification/frontEndTb.sv

/* Bender.yml */
package:
  name: frontEnd

sources:
  - include_dirs:
      - design
    files:
      - design/isaPkg.sv
      - design/dispatchPkg.sv
      - design/fetchUnit.sv
      - design/instrQueue.sv
      - design/issueUnit.sv
      - design/frontEnd.sv
  - target: test
    include_dirs:
      - design
      - verification
    files:
      - verification/frontEndTb.sv
